// File: bpPkg.sv
// shared definitions for the banked bimodal predictor
// table geometry, counter constants
// vector types for pc, bank rows, lane offsets and counters
// packed structs for the update port, bank writes and lane predictions

`default_nettype none

package bpPkg;

	// fetch geometry, four lanes per fetch
	localparam int FETCH_WIDTH      = 4;
	localparam int FETCH_WIDTH_LOG  = 2;
	localparam int NUM_BANKS        = FETCH_WIDTH;

	// pc layout
	localparam int SIZE_PC          = 32;
	localparam int INST_BYTE_OFFSET = 2;

	// 256 counters in total, 64 per bank
	localparam int CNT_TBL_LOG      = 8;
	localparam int BANK_INDEX       = CNT_TBL_LOG - FETCH_WIDTH_LOG;
	localparam int BANK_DEPTH       = 64;

	typedef logic [SIZE_PC-1:0]         pcT;
	typedef logic [BANK_INDEX-1:0]      bankIndexT;
	// bank number, doubles as rotation amount
	typedef logic [FETCH_WIDTH_LOG-1:0] laneOffsetT;
	typedef logic [1:0]                 counterT;
	// one bit per bank or lane
	typedef logic [NUM_BANKS-1:0]       laneMaskT;

	// counter values
	localparam counterT CNT_RESET = 2'd1;
	localparam counterT CNT_MAX   = 2'd3;

	// update request from the resolve side, en is a plain strobe
	typedef struct packed
	{
		logic    en;
		pcT      pc;
		logic    dir;
		counterT counter;
	} updateReqT;

	// one counter write, at most one bank enabled
	typedef struct packed
	{
		laneMaskT  bankEn;
		bankIndexT row;
		counterT   data;
	} bankWriteT;

	// prediction for a single lane
	typedef struct packed
	{
		logic    dir;
		counterT counter;
	} lanePredT;

	// lane 0 sits in the low bits
	typedef lanePredT [FETCH_WIDTH-1:0] predBundleT;

	// per bank read row and read data
	typedef bankIndexT [NUM_BANKS-1:0] bankRowsT;
	typedef counterT [NUM_BANKS-1:0]   bankCountersT;

endpackage

`default_nettype wire

// File: branchPredictor.sv
// top of the banked bimodal branch predictor
// four lane lookup router, update encoder and counter table
// prediction is combinational on pc_i, updates land at the clock edge

`timescale 1ns/10ps
`default_nettype none

module branchPredictor
(
	input  wire                   clk,
	input  wire                   rstN_i,
	input  wire bpPkg::pcT        pc_i,
	input  wire bpPkg::updateReqT update_i,
	output bpPkg::predBundleT     pred_o
);

	import bpPkg::*;

	// per bank read rows from the router
	bankRowsT     rdRows;
	// per bank counters back from the table
	bankCountersT rdCounters;
	// single write from the update encoder
	bankWriteT    bankWr;

	// lookup path, pc to lane predictions
	lookupRouter u_lookupRouter
	(
		.pc_i         (pc_i),
		.rdCounters_i (rdCounters),
		.rdRows_o     (rdRows),
		.pred_o       (pred_o)
	);

	// update path, no back-pressure
	counterUpdate u_counterUpdate
	(
		.update_i (update_i),
		.bankWr_o (bankWr)
	);

	// storage shared by both paths
	counterTable u_counterTable
	(
		.clk          (clk),
		.rstN_i       (rstN_i),
		.rdRows_i     (rdRows),
		.bankWr_i     (bankWr),
		.rdCounters_o (rdCounters)
	);

endmodule

`default_nettype wire

// File: branchPredictorTb.sv
// testbench for the banked bimodal branch predictor
// lfsr stimulus, 256 entry reference counter model, per cycle compare
// directed tests for reset, update timing, saturation and lane rotation
// random mix of lookups and updates

`timescale 1ns/10ps
`default_nettype none

module branchPredictorTb;

	import bpPkg::*;

	localparam int CLK_PERIOD    = 40;
	localparam int SLOT_SHIFT    = 2;
	localparam int TABLE_SIZE    = 1 << CNT_TBL_LOG;
	localparam int RESET_TIMEOUT = 20;
	localparam int RANDOM_CYCLES = 400;
	localparam int SIM_LIMIT_NS  = 100000;

	logic        clk;
	logic        rstN;
	logic [31:0] fetchPc;
	updateReqT   updateReq;
	predBundleT  pred;

	// reference counters, one per table entry
	logic [1:0]  refCnt [TABLE_SIZE];
	logic [31:0] lfsrState;
	string       testNames [5];
	int          testId;
	logic        compareOn;
	logic        timedOut;
	logic        runDone;
	int          errorCount;
	int          checkCount;

	tbClockGen u_tbClockGen
	(
		.clk_o  (clk),
		.rstN_o (rstN)
	);

	branchPredictor u_branchPredictor
	(
		.clk      (clk),
		.rstN_i   (rstN),
		.pc_i     (fetchPc),
		.update_i (updateReq),
		.pred_o   (pred)
	);

	// fibonacci lfsr, taps 32 22 2 1, one step per bit taken
	function automatic logic [31:0] takeRandomBits(input int count);
		logic [31:0] bits;
		logic        feedback;
		bits = '0;
		for (int i = 0; i < count; i++)
		begin
			feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], feedback};
			bits      = {bits[30:0], feedback};
		end
		return bits;
	endfunction

	// saturating two bit counter step
	function automatic logic [1:0] stepCounter(input logic [1:0] cnt, input logic taken);
		if (taken && cnt != 2'd3)
			return cnt + 2'd1;
		if (!taken && cnt != 2'd0)
			return cnt - 2'd1;
		return cnt;
	endfunction

	// expected four lane prediction for a fetch pc
	function automatic predBundleT refPredict(input logic [31:0] pcVal);
		predBundleT  result;
		int unsigned entry;
		for (int lane = 0; lane < FETCH_WIDTH; lane++)
		begin
			// consecutive slots, wrapping at the table end
			entry = ((pcVal >> SLOT_SHIFT) + 32'(lane)) % TABLE_SIZE;
			result[lane].counter = refCnt[entry];
			result[lane].dir     = (refCnt[entry] >= 2'd2);
		end
		return result;
	endfunction

	// pc hitting a table entry, random upper bits and byte offset
	function automatic logic [31:0] pcForEntry(input int entry);
		logic [31:0] pcVal;
		pcVal = takeRandomBits(32);
		pcVal[CNT_TBL_LOG+SLOT_SHIFT-1:SLOT_SHIFT] = CNT_TBL_LOG'(entry % TABLE_SIZE);
		return pcVal;
	endfunction

	// counter pattern for the rotation test
	function automatic logic [1:0] patternValue(input int entry);
		return 2'((entry + entry / 4) % 4);
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic waitFalling(input int count);
		int  edges;
		time startNs;
		edges = 0;
		while (!timedOut && edges < count)
		begin
			startNs = $time;
			// next falling edge, or give up after two clock periods
			fork
				@(negedge clk);
				#(2 * CLK_PERIOD);
			join_any
			if (($time - startNs) < 64'(2 * CLK_PERIOD))
			begin
				edges++;
			end
			else
			begin
				$display("expected %0d falling clock edges but they did not arrive in time",
					count);
				errorCount++;
				timedOut = 1'b1;
			end
		end
	endtask

	task automatic waitResetRelease();
		int waited;
		waited = 0;
		while (rstN !== 1'b1 && waited < RESET_TIMEOUT)
		begin
			@(negedge clk);
			waited++;
		end
		if (rstN !== 1'b1)
		begin
			$display("reset was still asserted after %0d clock cycles", RESET_TIMEOUT);
			errorCount++;
			timedOut = 1'b1;
		end
	endtask

	// drive one update strobe, no wait
	task automatic requestUpdate(input int entry, input logic taken, input logic [1:0] cnt);
		updateReqT req;
		req.en      = 1'b1;
		req.pc      = pcForEntry(entry);
		req.dir     = taken;
		req.counter = cnt;
		updateReq <= req;
	endtask

	// store a given value, supplied counter one step away
	task automatic writeEntry(input int entry, input logic [1:0] value);
		if (value == 2'd0)
			requestUpdate(entry, 1'b0, 2'd0);
		else
			requestUpdate(entry, 1'b1, value - 2'd1);
		waitFalling(1);
	endtask

	task automatic testResetState();
		testId <= 0;
		for (int i = 0; i < 40; i++)
		begin
			fetchPc <= takeRandomBits(32);
			waitFalling(1);
			// all four lanes weakly not-taken
			checkValue(testNames[0], 32'h249, 32'(pred));
		end
	endtask

	task automatic testUpdateVisibility();
		testId <= 1;
		// entry 77 sits in lane 2 of slot 75
		fetchPc <= pcForEntry(75);
		requestUpdate(77, 1'b1, 2'd1);
		// same cycle, before the write edge
		#(CLK_PERIOD / 4);
		checkValue(testNames[1], 32'(3'b001), 32'(pred[2]));
		waitFalling(1);
		updateReq <= '0;
		// next cycle sees the stepped counter
		checkValue(testNames[1], 32'(3'b110), 32'(pred[2]));
	endtask

	task automatic testSaturation();
		testId <= 2;
		requestUpdate(120, 1'b1, 2'd3);
		waitFalling(1);
		requestUpdate(121, 1'b0, 2'd0);
		waitFalling(1);
		// back to back on one entry, second one wins
		requestUpdate(122, 1'b1, 2'd1);
		waitFalling(1);
		requestUpdate(122, 1'b0, 2'd0);
		waitFalling(1);
		updateReq <= '0;
		fetchPc   <= pcForEntry(120);
		waitFalling(1);
		checkValue(testNames[2], 32'(3'b111), 32'(pred[0]));
		checkValue(testNames[2], 32'(3'b000), 32'(pred[1]));
		checkValue(testNames[2], 32'(3'b000), 32'(pred[2]));
	endtask

	task automatic testLaneRotation();
		int         bases [2];
		int         entry;
		logic [1:0] value;
		testId <= 3;
		// row 2 spill into row 3, and 255 wrapping to 0
		bases = '{8, 252};
		for (int i = 0; i < 7; i++)
		begin
			writeEntry(8 + i, patternValue(8 + i));
			writeEntry((252 + i) % TABLE_SIZE, patternValue((252 + i) % TABLE_SIZE));
		end
		updateReq <= '0;
		foreach (bases[b])
		begin
			for (int off = 0; off < FETCH_WIDTH; off++)
			begin
				fetchPc <= pcForEntry(bases[b] + off);
				waitFalling(1);
				for (int lane = 0; lane < FETCH_WIDTH; lane++)
				begin
					entry = (bases[b] + off + lane) % TABLE_SIZE;
					value = patternValue(entry);
					checkValue(testNames[3], 32'({value >= 2'd2, value}), 32'(pred[lane]));
				end
			end
		end
	endtask

	task automatic testRandomMix();
		logic [31:0] pcVal;
		updateReqT   req;
		testId <= 4;
		for (int i = 0; i < RANDOM_CYCLES; i++)
		begin
			pcVal       = takeRandomBits(32);
			req.en      = 1'(takeRandomBits(1));
			req.dir     = 1'(takeRandomBits(1));
			req.counter = 2'(takeRandomBits(2));
			// half the updates land inside the fetch window
			if (takeRandomBits(1) == 32'd1)
				req.pc = pcVal + (takeRandomBits(2) << SLOT_SHIFT);
			else
				req.pc = takeRandomBits(32);
			fetchPc   <= pcVal;
			updateReq <= req;
			waitFalling(1);
		end
		updateReq <= '0;
	endtask

	// reference model, tracks the table at each rising edge
	always @(posedge clk)
	begin
		int unsigned entry;
		entry = (updateReq.pc >> SLOT_SHIFT) % TABLE_SIZE;
		if (rstN !== 1'b1)
		begin
			for (int i = 0; i < TABLE_SIZE; i++)
				refCnt[i] = 2'd1;
		end
		else if (updateReq.en)
			refCnt[entry] = stepCounter(updateReq.counter, updateReq.dir);
	end

	// compare before the falling edge stimulus lands
	always @(negedge clk)
	begin
		if (compareOn)
			checkValue(testNames[testId], 32'(refPredict(fetchPc)), 32'(pred));
	end

	initial
	begin
		fetchPc    = '0;
		updateReq  = '0;
		compareOn  = 1'b0;
		testId     = 0;
		timedOut   = 1'b0;
		runDone    = 1'b0;
		errorCount = 0;
		checkCount = 0;
		lfsrState  = 32'hee57;
		testNames  = '{"reset state", "update visibility", "saturation", "lane rotation",
			"random mix"};
		waitResetRelease();
		compareOn <= 1'b1;
		testResetState();
		testUpdateVisibility();
		testSaturation();
		testLaneRotation();
		testRandomMix();
		// let the last compare settle
		#(CLK_PERIOD / 4);
		runDone = 1'b1;
		$display("summary: %0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// catches a stopped clock or a stuck run
	initial
	begin
		int waitedNs;
		waitedNs = 0;
		while (runDone !== 1'b1 && waitedNs < SIM_LIMIT_NS)
		begin
			#(CLK_PERIOD);
			waitedNs += CLK_PERIOD;
		end
		if (runDone !== 1'b1)
		begin
			$display("simulation did not finish within %0d ns", SIM_LIMIT_NS);
			$display("Errors found");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: counterTable.sv
// counter storage of the predictor
// four banks of 64 two-bit counters
// combinational read per bank, one write per cycle
// reset fills all entries with weakly not-taken

`timescale 1ns/10ps
`default_nettype none

module counterTable
(
	input  wire                      clk,
	input  wire                      rstN_i,
	input  wire bpPkg::bankRowsT     rdRows_i,
	input  wire bpPkg::bankWriteT    bankWr_i,
	output wire bpPkg::bankCountersT rdCounters_o
);

	import bpPkg::*;

	genvar bank;

	generate
		for (bank = 0; bank < NUM_BANKS; bank++)
		begin : gBank
			// counters of this bank
			counterT bankMem [BANK_DEPTH];

			always_ff @(posedge clk)
			begin
				if (!rstN_i)
				begin
					// every counter back to weakly not-taken
					// writes during reset are dropped
					for (int row = 0; row < BANK_DEPTH; row++)
					begin
						bankMem[row] <= CNT_RESET;
					end
				end
				else if (bankWr_i.bankEn[bank])
				begin
					// row is shared, only the enabled bank takes it
					bankMem[bankWr_i.row] <= bankWr_i.data;
				end
			end

			// read sees the old value in the cycle of a write
			assign rdCounters_o[bank] = bankMem[rdRows_i[bank]];
		end
	endgenerate

endmodule

`default_nettype wire

// File: counterUpdate.sv
// update side of the predictor
// saturating next value of the supplied counter
// bank row, bank select and write enable for one update

`timescale 1ns/10ps
`default_nettype none

module counterUpdate
(
	input  wire bpPkg::updateReqT update_i,
	output bpPkg::bankWriteT      bankWr_o
);

	import bpPkg::*;

	// slot bits of the update pc
	bankIndexT  wrRow;
	laneOffsetT wrBank;
	// stepped counter value
	counterT    nextCnt;

	// row from pc[9:4], bank from pc[3:2]
	assign wrRow  = update_i.pc[CNT_TBL_LOG+INST_BYTE_OFFSET-1:FETCH_WIDTH_LOG+INST_BYTE_OFFSET];
	assign wrBank = update_i.pc[FETCH_WIDTH_LOG+INST_BYTE_OFFSET-1:INST_BYTE_OFFSET];

	// saturating step of the caller's counter
	always_comb
	begin
		nextCnt = update_i.counter;
		if (update_i.dir)
		begin
			// taken, step up unless already strongly taken
			if (update_i.counter < CNT_MAX)
			begin
				nextCnt = update_i.counter + 2'd1;
			end
		end
		else
		begin
			// not taken, step down unless already at 0
			if (update_i.counter != '0)
			begin
				nextCnt = update_i.counter - 2'd1;
			end
		end
	end

	// write request to the table
	always_comb
	begin
		bankWr_o.row  = wrRow;
		bankWr_o.data = nextCnt;
		// one hot enable, all clear without the strobe
		for (int bank = 0; bank < NUM_BANKS; bank++)
		begin
			bankWr_o.bankEn[bank] = update_i.en && (wrBank == laneOffsetT'(bank));
		end
	end

endmodule

`default_nettype wire

// File: filelist.f
bpPkg.sv
lookupRouter.sv
counterUpdate.sv
counterTable.sv
branchPredictor.sv
tbClockGen.sv
branchPredictorTb.sv

// File: lookupRouter.sv
// lookup side of the predictor
// per lane table index from the fetch pc
// read row rotation onto the banks, counter rotation back to lanes
// taken decision per lane

`timescale 1ns/10ps
`default_nettype none

module lookupRouter
(
	input  wire bpPkg::pcT           pc_i,
	input  wire bpPkg::bankCountersT rdCounters_i,
	output bpPkg::bankRowsT          rdRows_o,
	output bpPkg::predBundleT        pred_o
);

	import bpPkg::*;

	// fetch slot bits that select a table entry
	logic [CNT_TBL_LOG-1:0] slotIndex;
	// table entry of each lane
	logic [CNT_TBL_LOG-1:0] laneEntry [FETCH_WIDTH];
	bankIndexT              laneRow   [FETCH_WIDTH];
	laneOffsetT             laneBank  [FETCH_WIDTH];
	// counters already back in lane order
	counterT                laneCounter [FETCH_WIDTH];
	// bank holding lane 0
	laneOffsetT             rotate;

	// pc without byte offset, only low table bits matter
	assign slotIndex = pc_i[CNT_TBL_LOG+INST_BYTE_OFFSET-1:INST_BYTE_OFFSET];

	always_comb
	begin
		for (int lane = 0; lane < FETCH_WIDTH; lane++)
		begin
			// consecutive slots, wraps from entry 255 to 0
			laneEntry[lane] = slotIndex + CNT_TBL_LOG'(lane);
			// high bits pick the row, low bits the bank
			laneRow[lane]   = laneEntry[lane][CNT_TBL_LOG-1:FETCH_WIDTH_LOG];
			laneBank[lane]  = laneEntry[lane][FETCH_WIDTH_LOG-1:0];
		end
	end

	assign rotate = laneBank[0];

	// lanes past the last bank spill into the next row of the low banks
	// since each lane carries its own row, no extra correction is needed

	// rotate read rows onto the banks
	always_comb
	begin
		rdRows_o = '0;
		for (int lane = 0; lane < FETCH_WIDTH; lane++)
		begin
			// bank (lane + rotate) mod 4, the 2-bit add wraps by itself
			rdRows_o[laneOffsetT'(lane) + rotate] = laneRow[lane];
		end
	end

	// rotate bank data back into lane order
	always_comb
	begin
		for (int lane = 0; lane < FETCH_WIDTH; lane++)
		begin
			laneCounter[lane] = rdCounters_i[laneOffsetT'(lane) + rotate];
		end
	end

	// direction from counter
	always_comb
	begin
		for (int lane = 0; lane < FETCH_WIDTH; lane++)
		begin
			pred_o[lane].counter = laneCounter[lane];
			// msb set means 2 or 3, i.e. weakly or strongly taken
			pred_o[lane].dir     = laneCounter[lane][1];
		end
	end

endmodule

`default_nettype wire

// File: runSim.sh
#!/bin/sh
# build and run the branch predictor testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
	--timescale 1ns/10ps \
	-f filelist.f \
	--top-module branchPredictorTb \
	--Mdir obj_dir \
	-o simBp

./obj_dir/simBp | tee sim.log

if grep -qx "No errors" sim.log
then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// File: tbClockGen.sv
// testbench clock and reset source
// 40 ns clock, active low reset held for three cycles

`timescale 1ns/10ps
`default_nettype none

module tbClockGen
(
	output logic clk_o,
	output logic rstN_o
);

	localparam int HALF_PERIOD  = 20;
	localparam int RESET_CYCLES = 3;

	// free running clock, starts low
	initial
	begin
		clk_o = 1'b0;
		forever
		begin
			#(HALF_PERIOD);
			clk_o = ~clk_o;
		end
	end

	// release on a falling edge, well away from the sampling edge
	initial
	begin
		rstN_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		rstN_o <= 1'b1;
	end

endmodule

`default_nettype wire
